// ==== hw/xlate_pkg.sv ====
// Shared widths, encodings and packed structs for the data translation stage
// Sv39 only: 39-bit virtual, 40-bit physical, 4 KiB pages, no superpages
// Physical tags below DRAM_BASE_PTAG are treated as uncached I/O space
// The device-ID field is the top IO_DID_WIDTH bits of the physical tag

package xlate_pkg;

  // Address geometry
  localparam int VADDR_WIDTH       = 39;
  localparam int PADDR_WIDTH       = 40;
  localparam int PAGE_OFFSET_WIDTH = 12;
  localparam int VTAG_WIDTH        = VADDR_WIDTH - PAGE_OFFSET_WIDTH;
  localparam int PTAG_WIDTH        = PADDR_WIDTH - PAGE_OFFSET_WIDTH;

  // Data TLB geometry
  localparam int DTLB_ENTRIES   = 8;
  localparam int ENTRY_ID_WIDTH = $clog2(DTLB_ENTRIES);

  // Memory map
  localparam int IO_DID_WIDTH = 3;
  localparam logic [PTAG_WIDTH-1:0] DRAM_BASE_PTAG = 28'h0080000;

  // Privilege encoding as in mstatus.MPP
  typedef enum logic [1:0] {
    e_priv_u = 2'd0,
    e_priv_s = 2'd1,
    e_priv_m = 2'd3
  } priv_mode_e;

  // Leaf PTE bits kept by the TLB
  typedef struct packed {
    logic [PTAG_WIDTH-1:0] ptag;
    logic                  u;
    logic                  w;
    logic                  d;
  } pte_leaf_s;

  // TLB fill payload
  typedef struct packed {
    logic [VTAG_WIDTH-1:0] vtag;
    pte_leaf_s             pte;
  } tlb_fill_s;

  // Load or store command
  typedef struct packed {
    logic [VADDR_WIDTH-1:0] vaddr;
    logic                   is_store;
  } xlate_cmd_s;

  // Level configuration, normally sourced from the CSR file
  typedef struct packed {
    priv_mode_e priv_mode;
    logic       sum;
    logic       translation_en;
    logic       uncached_mode;
  } xlate_cfg_s;

  // Translation result
  typedef struct packed {
    logic [PADDR_WIDTH-1:0] paddr;
    logic                   miss;
    logic                   load_page_fault;
    logic                   store_page_fault;
    logic                   load_access_fault;
    logic                   store_access_fault;
    logic                   uncached;
  } xlate_resp_s;

endpackage

// ==== hw/tlb_fill_ctrl.sv ====
// Victim selection for data TLB fills
// Free entries fill lowest index first and leave the pointer alone
// With all entries valid, a round-robin pointer picks the victim
// Flush is not seen here, so a fill lost to a flush may still move the pointer

`timescale 1ns/1ps

module tlb_fill_ctrl (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             fill_v_i,
  input  logic [xlate_pkg::DTLB_ENTRIES-1:0] entry_v_i,
  output logic [xlate_pkg::DTLB_ENTRIES-1:0] entry_w_o
);
  import xlate_pkg::*;

  logic [ENTRY_ID_WIDTH-1:0] victim_r;
  logic [ENTRY_ID_WIDTH-1:0] free_id;
  logic [ENTRY_ID_WIDTH-1:0] w_id;
  logic                      has_free;

  // Lowest invalid entry
  always_comb begin
    has_free = 1'b0;
    free_id  = '0;
    for (int i = DTLB_ENTRIES - 1; i >= 0; i--) begin
      if (!entry_v_i[i]) begin
        has_free = 1'b1;
        free_id  = ENTRY_ID_WIDTH'(i);
      end
    end
  end

  assign w_id = has_free ? free_id : victim_r;

  always_comb begin
    entry_w_o       = '0;
    entry_w_o[w_id] = fill_v_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      victim_r <= '0;
    end else if (fill_v_i && !has_free) begin
      if (victim_r == ENTRY_ID_WIDTH'(DTLB_ENTRIES - 1)) begin
        victim_r <= '0;
      end else begin
        victim_r <= victim_r + 1'b1;
      end
    end
  end

endmodule

// ==== hw/tlb_entry.sv ====
// One fully associative data TLB entry
// Write takes one cycle; the tag compare is combinational
// Flush and reset clear only the valid bit, tag and PTE keep stale data
// Flush beats a write in the same cycle

`timescale 1ns/1ps

module tlb_entry (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             flush_i,
  input  logic                             w_i,
  input  xlate_pkg::tlb_fill_s             fill_i,
  input  logic [xlate_pkg::VTAG_WIDTH-1:0] vtag_i,
  output logic                             v_o,
  output logic                             hit_o,
  output xlate_pkg::pte_leaf_s             pte_o
);
  import xlate_pkg::*;

  logic                  v_r;
  logic [VTAG_WIDTH-1:0] vtag_r;
  pte_leaf_s             pte_r;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      v_r <= 1'b0;
    end else if (w_i) begin
      v_r <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_i) begin
      vtag_r <= fill_i.vtag;
      pte_r  <= fill_i.pte;
    end
  end

  assign v_o   = v_r;
  assign hit_o = v_r && (vtag_r == vtag_i);
  assign pte_o = pte_r;

endmodule

// ==== hw/xlate_check.sv ====
// Translation check: hit select, two pipeline stages, permission and PMA checks
// Latency is fixed at 2 cycles, no back-pressure
// poison_i only kills the command sitting in stage 1
// Config is sampled with the command so each command sees its own level
// On a miss all fault flags and uncached read as zero

`timescale 1ns/1ps

module xlate_check (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic                                    cmd_v_i,
  input  xlate_pkg::xlate_cmd_s                   cmd_i,
  input  xlate_pkg::xlate_cfg_s                   cfg_i,
  input  logic                                    poison_i,
  input  logic [xlate_pkg::DTLB_ENTRIES-1:0]      hit_i,
  input  xlate_pkg::pte_leaf_s [xlate_pkg::DTLB_ENTRIES-1:0] pte_i,
  output logic                                    resp_v_o,
  output xlate_pkg::xlate_resp_s                  resp_o
);
  import xlate_pkg::*;

  // Stage 0 select
  pte_leaf_s sel_pte;
  logic      any_hit;

  // Stage 1 registers
  logic       cmd_v_r;
  xlate_cmd_s cmd_r;
  xlate_cfg_s cfg_r;
  logic       hit_r;
  pte_leaf_s  pte_r;

  // Stage 1 results
  logic                   xlate_on;
  logic                   lookup_ok;
  logic                   page_ok;
  logic [PADDR_WIDTH-1:0] paddr;
  logic [PTAG_WIDTH-1:0]  ptag;
  logic                   below_dram;
  logic                   priv_fault;
  logic                   write_fault;
  logic                   mode_fault;
  logic                   did_fault;
  logic                   access_fault;
  xlate_resp_s            resp_next;

  // Lowest index wins if a tag was filled twice
  always_comb begin
    sel_pte = '0;
    for (int i = DTLB_ENTRIES - 1; i >= 0; i--) begin
      if (hit_i[i]) begin
        sel_pte = pte_i[i];
      end
    end
  end

  assign any_hit = |hit_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cmd_v_r <= 1'b0;
    end else begin
      cmd_v_r <= cmd_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    cmd_r <= cmd_i;
    cfg_r <= cfg_i;
    hit_r <= any_hit;
    pte_r <= sel_pte;
  end

  assign xlate_on  = cfg_r.translation_en;
  assign lookup_ok = !xlate_on || hit_r;
  assign page_ok   = xlate_on && hit_r;

  // Bare mode zero-extends the virtual address
  assign paddr = xlate_on ? {pte_r.ptag, cmd_r.vaddr[PAGE_OFFSET_WIDTH-1:0]}
                          : PADDR_WIDTH'(cmd_r.vaddr);
  assign ptag  = paddr[PADDR_WIDTH-1 -: PTAG_WIDTH];

  assign below_dram = (ptag < DRAM_BASE_PTAG);

  // SUM lets S mode touch user pages
  assign priv_fault = ((cfg_r.priv_mode == e_priv_s) && !cfg_r.sum && pte_r.u)
                    || ((cfg_r.priv_mode == e_priv_u) && !pte_r.u);
  assign write_fault = !pte_r.w || !pte_r.d;

  // PMA checks
  assign mode_fault   = cfg_r.uncached_mode && !below_dram;
  assign did_fault    = (ptag[PTAG_WIDTH-1 -: IO_DID_WIDTH] != '0);
  assign access_fault = lookup_ok && (mode_fault || did_fault);

  always_comb begin
    resp_next.paddr              = paddr;
    resp_next.miss               = !lookup_ok;
    resp_next.load_page_fault    = page_ok && !cmd_r.is_store && priv_fault;
    resp_next.store_page_fault   = page_ok && cmd_r.is_store && (priv_fault || write_fault);
    resp_next.load_access_fault  = access_fault && !cmd_r.is_store;
    resp_next.store_access_fault = access_fault && cmd_r.is_store;
    resp_next.uncached           = lookup_ok && below_dram;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_o <= 1'b0;
    end else begin
      resp_v_o <= cmd_v_r && !poison_i;
    end
  end

  always_ff @(posedge clk_i) begin
    resp_o <= resp_next;
  end

endmodule

// ==== hw/mem_xlate_top.sv ====
// Data address translation stage
// Command to response latency is 2 cycles, one command per cycle, no ready
// Fills come from outside on fill_v_i; there is no page-table walker
// A fill or flush is visible to lookups from the next cycle on

`timescale 1ns/1ps

module mem_xlate_top (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   cmd_v_i,
  input  xlate_pkg::xlate_cmd_s  cmd_i,
  input  xlate_pkg::xlate_cfg_s  cfg_i,
  input  logic                   poison_i,
  input  logic                   fill_v_i,
  input  logic                   flush_i,
  input  xlate_pkg::tlb_fill_s   fill_i,
  output logic                   resp_v_o,
  output xlate_pkg::xlate_resp_s resp_o
);
  import xlate_pkg::*;

  logic [DTLB_ENTRIES-1:0]  entry_v;
  logic [DTLB_ENTRIES-1:0]  entry_w;
  logic [DTLB_ENTRIES-1:0]  entry_hit;
  pte_leaf_s [DTLB_ENTRIES-1:0] entry_pte;
  logic [VTAG_WIDTH-1:0]    cmd_vtag;

  assign cmd_vtag = cmd_i.vaddr[VADDR_WIDTH-1 -: VTAG_WIDTH];

  tlb_fill_ctrl fill_ctrl (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .fill_v_i  (fill_v_i),
    .entry_v_i (entry_v),
    .entry_w_o (entry_w)
  );

  for (genvar i = 0; i < DTLB_ENTRIES; i++) begin : g_entry
    tlb_entry entry (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .flush_i (flush_i),
      .w_i     (entry_w[i]),
      .fill_i  (fill_i),
      .vtag_i  (cmd_vtag),
      .v_o     (entry_v[i]),
      .hit_o   (entry_hit[i]),
      .pte_o   (entry_pte[i])
    );
  end

  xlate_check check (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .cmd_v_i  (cmd_v_i),
    .cmd_i    (cmd_i),
    .cfg_i    (cfg_i),
    .poison_i (poison_i),
    .hit_i    (entry_hit),
    .pte_i    (entry_pte),
    .resp_v_o (resp_v_o),
    .resp_o   (resp_o)
  );

endmodule

// ==== test/tb_mem_xlate.sv ====
// Directed testbench for the data address translation stage
// Expected responses come from a TLB model kept beside the DUT
// Each response is checked 2 cycles after its command; paddr is ignored on a miss

`timescale 1ns/1ps

module tb_mem_xlate;
  import xlate_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;

  logic        clk_i;
  logic        reset_i;
  logic        cmd_v_i;
  xlate_cmd_s  cmd_i;
  xlate_cfg_s  cfg_i;
  logic        poison_i;
  logic        fill_v_i;
  logic        flush_i;
  tlb_fill_s   fill_i;
  logic        resp_v_o;
  xlate_resp_s resp_o;

  // TLB model
  logic                  m_v    [DTLB_ENTRIES];
  logic [VTAG_WIDTH-1:0] m_vtag [DTLB_ENTRIES];
  pte_leaf_s             m_pte  [DTLB_ENTRIES];
  int                    m_victim;

  xlate_resp_s exp_q[$];
  int          due_q[$];
  int          cycle_cnt = 0;
  int          check_cnt = 0;
  int          err_cnt = 0;
  integer      seed;

  mem_xlate_top dut (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .cmd_v_i  (cmd_v_i),
    .cmd_i    (cmd_i),
    .cfg_i    (cfg_i),
    .poison_i (poison_i),
    .fill_v_i (fill_v_i),
    .flush_i  (flush_i),
    .fill_i   (fill_i),
    .resp_v_o (resp_v_o),
    .resp_o   (resp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycle_cnt);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic xlate_cfg_s make_cfg(priv_mode_e priv, logic sum, logic xl, logic unc);
    xlate_cfg_s c;
    c.priv_mode      = priv;
    c.sum            = sum;
    c.translation_en = xl;
    c.uncached_mode  = unc;
    return c;
  endfunction

  function automatic pte_leaf_s make_pte(logic [PTAG_WIDTH-1:0] ptag, logic u, logic w, logic d);
    pte_leaf_s p;
    p.ptag = ptag;
    p.u    = u;
    p.w    = w;
    p.d    = d;
    return p;
  endfunction

  function automatic logic [PAGE_OFFSET_WIDTH-1:0] rand_off();
    return PAGE_OFFSET_WIDTH'($random(seed));
  endfunction

  function automatic logic [VTAG_WIDTH-1:0] rand_tag();
    return VTAG_WIDTH'($random(seed));
  endfunction

  // Cached ptag with a zero device-ID field
  function automatic logic [PTAG_WIDTH-1:0] rand_cached_ptag();
    return DRAM_BASE_PTAG + PTAG_WIDTH'($random(seed) & 32'hffff);
  endfunction

  function automatic xlate_resp_s predict_resp(xlate_cmd_s cmd, xlate_cfg_s cfg);
    xlate_resp_s           r;
    logic                  hit;
    pte_leaf_s             pte;
    logic [PTAG_WIDTH-1:0] pt;
    logic                  priv_f;
    logic                  acc_f;
    int                    i;
    r   = '0;
    hit = 1'b0;
    pte = '0;
    for (i = 0; i < DTLB_ENTRIES; i++) begin
      if (!hit && m_v[i] && m_vtag[i] == cmd.vaddr[VADDR_WIDTH-1:PAGE_OFFSET_WIDTH]) begin
        hit = 1'b1;
        pte = m_pte[i];
      end
    end
    if (cfg.translation_en && !hit) begin
      r.miss = 1'b1;
      return r;
    end
    if (cfg.translation_en) begin
      r.paddr = {pte.ptag, cmd.vaddr[PAGE_OFFSET_WIDTH-1:0]};
    end else begin
      r.paddr = {1'b0, cmd.vaddr};
    end
    pt         = r.paddr[PADDR_WIDTH-1:PAGE_OFFSET_WIDTH];
    r.uncached = (pt < DRAM_BASE_PTAG);
    case (cfg.priv_mode)
      e_priv_u: priv_f = !pte.u;
      e_priv_s: priv_f = pte.u && !cfg.sum;
      default:  priv_f = 1'b0;
    endcase
    if (cfg.translation_en) begin
      r.load_page_fault  = !cmd.is_store && priv_f;
      r.store_page_fault = cmd.is_store && (priv_f || !pte.w || !pte.d);
    end
    acc_f = (cfg.uncached_mode && !r.uncached) || (pt[PTAG_WIDTH-1 -: IO_DID_WIDTH] != '0);
    r.load_access_fault  = acc_f && !cmd.is_store;
    r.store_access_fault = acc_f && cmd.is_store;
    return r;
  endfunction

  task automatic check_next();
    xlate_resp_s exp;
    int          due;
    exp = exp_q.pop_front();
    due = due_q.pop_front();
    check_cnt++;
    if (!resp_v_o) begin
      err_cnt++;
      $display("no response at %0t for the command due in cycle %0d", $time, due);
    end else if (exp.miss ? (resp_o[5:0] != exp[5:0]) : (resp_o != exp)) begin
      // Low six bits hold the flags
      err_cnt++;
      $display("mismatch at %0t: resp got %h expected %h", $time, resp_o, exp);
    end
  endtask

  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (due_q.size() != 0 && due_q[0] == cycle_cnt) begin
        check_next();
      end else if (resp_v_o) begin
        err_cnt++;
        $display("response at %0t with no command pending", $time);
      end
    end
  end

  task automatic drive_idle();
    @(posedge clk_i);
    #1;
    cmd_v_i  = 1'b0;
    poison_i = 1'b0;
    fill_v_i = 1'b0;
    flush_i  = 1'b0;
  endtask

  // kill_prev poisons the command issued one cycle earlier
  task automatic send_cmd(logic [VADDR_WIDTH-1:0] vaddr, logic st, xlate_cfg_s cfg,
                          logic kill_prev);
    drive_idle();
    cmd_v_i        = 1'b1;
    cmd_i.vaddr    = vaddr;
    cmd_i.is_store = st;
    cfg_i          = cfg;
    poison_i       = kill_prev;
    if (kill_prev) begin
      exp_q.delete(exp_q.size() - 1);
      due_q.delete(due_q.size() - 1);
    end
    exp_q.push_back(predict_resp(cmd_i, cfg));
    due_q.push_back(cycle_cnt + 2);
  endtask

  // Victim choice: lowest invalid entry, else round-robin pointer
  task automatic fill_entry(logic [VTAG_WIDTH-1:0] vtag, pte_leaf_s pte);
    int id;
    int i;
    drive_idle();
    fill_v_i    = 1'b1;
    fill_i.vtag = vtag;
    fill_i.pte  = pte;
    id = -1;
    for (i = DTLB_ENTRIES - 1; i >= 0; i--) begin
      if (!m_v[i]) begin
        id = i;
      end
    end
    if (id < 0) begin
      id       = m_victim;
      m_victim = (m_victim + 1) % DTLB_ENTRIES;
    end
    m_v[id]    = 1'b1;
    m_vtag[id] = vtag;
    m_pte[id]  = pte;
  endtask

  task automatic clear_model();
    int i;
    for (i = 0; i < DTLB_ENTRIES; i++) begin
      m_v[i] = 1'b0;
    end
  endtask

  task automatic flush_tlb();
    drive_idle();
    flush_i = 1'b1;
    clear_model();
  endtask

  task automatic wait_drain();
    drive_idle();
    while (due_q.size() != 0) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic report_test(string name, int errs_before);
    $display("%s: %s", name, (err_cnt == errs_before) ? "passed" : "failed");
  endtask

  task automatic test_pass_through();
    xlate_cfg_s bare;
    xlate_cfg_s bare_unc;
    int         errs;
    errs     = err_cnt;
    bare     = make_cfg(e_priv_m, 1'b0, 1'b0, 1'b0);
    bare_unc = make_cfg(e_priv_m, 1'b0, 1'b0, 1'b1);
    send_cmd({27'h0010000, rand_off()}, 1'b0, bare, 1'b0);
    send_cmd({27'h0080123, rand_off()}, 1'b1, bare, 1'b0);
    send_cmd({27'h0080123, rand_off()}, 1'b0, bare_unc, 1'b0);
    send_cmd({27'h0010000, rand_off()}, 1'b1, bare_unc, 1'b0);
    send_cmd({rand_tag(), rand_off()}, 1'b1, bare, 1'b0);
    wait_drain();
    report_test("pass-through", errs);
  endtask

  task automatic test_miss_fill_hit();
    xlate_cfg_s            m_on;
    logic [VTAG_WIDTH-1:0] tag;
    int                    errs;
    errs = err_cnt;
    m_on = make_cfg(e_priv_m, 1'b0, 1'b1, 1'b0);
    tag  = rand_tag();
    send_cmd({tag, rand_off()}, 1'b0, m_on, 1'b0);
    wait_drain();
    fill_entry(tag, make_pte(rand_cached_ptag(), 1'b0, 1'b1, 1'b1));
    send_cmd({tag, rand_off()}, 1'b0, m_on, 1'b0);
    send_cmd({tag, rand_off()}, 1'b1, m_on, 1'b0);
    wait_drain();
    report_test("miss, fill, hit", errs);
  endtask

  task automatic test_page_faults();
    xlate_cfg_s            u_on;
    xlate_cfg_s            s_on;
    xlate_cfg_s            s_sum;
    logic [VTAG_WIDTH-1:0] base;
    int                    errs;
    errs  = err_cnt;
    u_on  = make_cfg(e_priv_u, 1'b0, 1'b1, 1'b0);
    s_on  = make_cfg(e_priv_s, 1'b0, 1'b1, 1'b0);
    s_sum = make_cfg(e_priv_s, 1'b1, 1'b1, 1'b0);
    base  = rand_tag();
    fill_entry(base + 1, make_pte(rand_cached_ptag(), 1'b0, 1'b1, 1'b1));
    fill_entry(base + 2, make_pte(rand_cached_ptag(), 1'b1, 1'b1, 1'b1));
    fill_entry(base + 3, make_pte(rand_cached_ptag(), 1'b0, 1'b0, 1'b1));
    fill_entry(base + 4, make_pte(rand_cached_ptag(), 1'b0, 1'b1, 1'b0));
    send_cmd({base + 27'd1, rand_off()}, 1'b0, u_on, 1'b0);
    send_cmd({base + 27'd2, rand_off()}, 1'b0, u_on, 1'b0);
    send_cmd({base + 27'd2, rand_off()}, 1'b0, s_on, 1'b0);
    send_cmd({base + 27'd2, rand_off()}, 1'b0, s_sum, 1'b0);
    send_cmd({base + 27'd3, rand_off()}, 1'b1, s_on, 1'b0);
    send_cmd({base + 27'd3, rand_off()}, 1'b0, s_on, 1'b0);
    send_cmd({base + 27'd4, rand_off()}, 1'b1, s_on, 1'b0);
    send_cmd({base + 27'd4, rand_off()}, 1'b0, s_on, 1'b0);
    wait_drain();
    report_test("page faults", errs);
  endtask

  task automatic test_access_faults();
    xlate_cfg_s            m_on;
    xlate_cfg_s            m_unc;
    logic [VTAG_WIDTH-1:0] base;
    int                    errs;
    errs  = err_cnt;
    m_on  = make_cfg(e_priv_m, 1'b0, 1'b1, 1'b0);
    m_unc = make_cfg(e_priv_m, 1'b0, 1'b1, 1'b1);
    base  = rand_tag();
    fill_entry(base, make_pte(28'h2080000 + PTAG_WIDTH'(rand_off()), 1'b0, 1'b1, 1'b1));
    fill_entry(base + 1, make_pte(rand_cached_ptag(), 1'b0, 1'b1, 1'b1));
    fill_entry(base + 2, make_pte(28'h0001000 + PTAG_WIDTH'(rand_off()), 1'b0, 1'b1, 1'b1));
    send_cmd({base, rand_off()}, 1'b0, m_on, 1'b0);
    send_cmd({base, rand_off()}, 1'b1, m_on, 1'b0);
    send_cmd({base + 27'd1, rand_off()}, 1'b0, m_unc, 1'b0);
    send_cmd({base + 27'd2, rand_off()}, 1'b1, m_unc, 1'b0);
    send_cmd({base + 27'd2, rand_off()}, 1'b0, m_on, 1'b0);
    wait_drain();
    report_test("access faults", errs);
  endtask

  task automatic test_poison_flush();
    xlate_cfg_s            m_on;
    logic [VTAG_WIDTH-1:0] tag;
    int                    errs;
    errs = err_cnt;
    m_on = make_cfg(e_priv_m, 1'b0, 1'b1, 1'b0);
    tag  = rand_tag();
    flush_tlb();
    fill_entry(tag, make_pte(rand_cached_ptag(), 1'b0, 1'b1, 1'b1));
    send_cmd({tag, rand_off()}, 1'b0, m_on, 1'b0);
    send_cmd({tag, rand_off()}, 1'b1, m_on, 1'b1);
    wait_drain();
    flush_tlb();
    send_cmd({tag, rand_off()}, 1'b0, m_on, 1'b0);
    wait_drain();
    report_test("poison and flush", errs);
  endtask

  task automatic test_replacement();
    xlate_cfg_s            m_on;
    logic [VTAG_WIDTH-1:0] base;
    int                    errs;
    int                    i;
    errs = err_cnt;
    m_on = make_cfg(e_priv_m, 1'b0, 1'b1, 1'b0);
    base = rand_tag();
    flush_tlb();
    for (i = 0; i <= DTLB_ENTRIES; i++) begin
      fill_entry(base + VTAG_WIDTH'(i), make_pte(rand_cached_ptag(), 1'b0, 1'b1, 1'b1));
    end
    for (i = 0; i <= DTLB_ENTRIES; i++) begin
      send_cmd({base + VTAG_WIDTH'(i), rand_off()}, 1'b0, m_on, 1'b0);
    end
    wait_drain();
    report_test("replacement", errs);
  endtask

  initial begin
    seed     = 32'h2814;
    reset_i  = 1'b1;
    cmd_v_i  = 1'b0;
    cmd_i    = '0;
    cfg_i    = '0;
    poison_i = 1'b0;
    fill_v_i = 1'b0;
    flush_i  = 1'b0;
    fill_i   = '0;
    m_victim = 0;
    clear_model();
    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    test_pass_through();
    test_miss_fill_hit();
    test_page_faults();
    test_access_faults();
    test_poison_flush();
    test_replacement();
    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
hw/xlate_pkg.sv
hw/tlb_fill_ctrl.sv
hw/tlb_entry.sv
hw/xlate_check.sv
hw/mem_xlate_top.sv
test/tb_mem_xlate.sv
